/* vlog.f */
+incdir+tests
common/rv32_pkg.sv
regfile/regfile.sv
decode/control_decoder.sv
decode/id_stage.sv
rtl/inst_predecode.sv
rtl/decode_top.sv
tests/tb_decode_top.sv

/* tests/decode_checks.svh */
`ifndef DECODE_CHECKS_SVH
`define DECODE_CHECKS_SVH

task automatic check_word(input string what, input word_t exp, input word_t act);
    if (exp !== act) begin
        errors++;
        $display("ERROR %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
endtask

task automatic check_order(input string what, input order_t exp, input order_t act);
    if (exp !== act) begin
        errors++;
        $display("ERROR %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
endtask

task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act) begin
        errors++;
        $display("ERROR %s %s: expected %b, actual %b", cur_test, what, exp, act);
    end
endtask

task automatic check_ctrl(input string what, input ex_signal_t ex, input mem_signal_t mem,
                          input wb_signal_t wb, input logic ill);
    if (id_ex.ex_signal !== ex || id_ex.mem_signal !== mem ||
        id_ex.wb_signal !== wb || id_ex.illegal !== ill) begin
        errors++;
        $display("ERROR %s %s: expected %h %h %h %b, actual %h %h %h %b", cur_test, what,
                 ex, mem, wb, ill, id_ex.ex_signal, id_ex.mem_signal, id_ex.wb_signal,
                 id_ex.illegal);
    end
endtask

function automatic word_t encode_inst(input logic [6:0] funct7, input reg_sel_t rs2,
                                      input reg_sel_t rs1, input logic [2:0] funct3,
                                      input reg_sel_t rd, input opcode_t opcode);
    return {funct7, rs2, rs1, funct3, rd, opcode};
endfunction

// bits is the width of the immediate, msb is its sign
function automatic word_t sign_extend(input word_t value, input int bits);
    return word_t'($signed(value << (32 - bits)) >>> (32 - bits));
endfunction

task automatic decode_case(input string what, input word_t inst, input ex_signal_t ex,
                           input mem_signal_t mem, input wb_signal_t wb, input logic ill);
    issue_fetch(1'b1, inst);
    check_flag({what, " valid"}, 1'b1, id_ex.valid);
    check_flag({what, " is_stall"}, 1'b0, id_ex.is_stall);
    check_ctrl(what, ex, mem, wb, ill);
endtask

task automatic check_idle_enables(input string what);
    check_flag({what, " valid"}, 1'b0, id_ex.valid);
    check_flag({what, " regf_we"}, 1'b0, id_ex.wb_signal.regf_we);
    check_flag({what, " MemRead"}, 1'b0, id_ex.mem_signal.MemRead);
    check_flag({what, " MemWrite"}, 1'b0, id_ex.mem_signal.MemWrite);
    check_flag({what, " illegal"}, 1'b0, id_ex.illegal);
    check_flag({what, " is_stall"}, 1'b0, id_ex.is_stall);
endtask

task automatic test_reset_state();
    begin_test("reset");
    check_idle_enables("after reset");
    check_order("order", ORDER_INIT, id_ex.order);
    end_test();
endtask

task automatic test_regfile_readback();
    reg_sel_t rs1;
    reg_sel_t rs2;
    begin_test("regfile");
    for (int r = 1; r < 32; r++) begin
        shadow[r] = $urandom();
        wb_write(reg_sel_t'(r), shadow[r]);
    end
    for (int r = 1; r < 32; r += 2) begin
        rs1 = reg_sel_t'(r);
        rs2 = reg_sel_t'(r % 31 + 1);  // x31 pairs with x1
        issue_fetch(1'b1, encode_inst(7'h00, rs2, rs1, 3'b000, 5'd1, op_reg));
        check_word("rs1_v", shadow[rs1], id_ex.rs1_v);
        check_word("rs2_v", shadow[rs2], id_ex.rs2_v);
    end
    end_test();
endtask

task automatic test_x0_and_forwarding();
    word_t fresh;
    begin_test("x0_forward");
    fresh = $urandom();
    wb_write(5'd0, 32'hdead_beef);
    issue_fetch(1'b1, encode_inst(7'h00, 5'd0, 5'd0, 3'b000, 5'd2, op_reg));
    check_word("x0 rs1_v", '0, id_ex.rs1_v);
    check_word("x0 rs2_v", '0, id_ex.rs2_v);
    issue_fetch(1'b1, encode_inst(7'h00, 5'd0, 5'd7, 3'b000, 5'd2, op_reg));
    check_word("x7 old", shadow[7], id_ex.rs1_v);
    @(posedge clk);
    #1;
    wb_regf_we = 1'b1;
    wb_rd_s    = 5'd7;
    wb_rd_v    = fresh;
    #6;
    check_word("x7 forwarded", fresh, id_ex.rs1_v);
    @(posedge clk);
    #1;
    wb_rd_s = 5'd0;  // x0 written while rs2 reads it
    wb_rd_v = '1;
    #6;
    check_word("x7 stored", fresh, id_ex.rs1_v);
    check_word("x0 forward", '0, id_ex.rs2_v);
    @(posedge clk);
    #1;
    wb_regf_we = 1'b0;
    #6;
    shadow[7] = fresh;
    end_test();
endtask

task automatic test_control_classes();
    ex_signal_t  ex_def;
    ex_signal_t  ex_addr;
    mem_signal_t mem_none;
    begin_test("control");
    ex_def   = '{alu_m1_rs1, alu_m2_rs2, alu_add, cmp_m_rs2, cmp_beq};
    ex_addr  = '{alu_m1_rs1, alu_m2_imm, alu_add, cmp_m_rs2, cmp_beq};
    mem_none = '0;
    decode_case("lui", encode_inst(7'h12, 5'd3, 5'd2, 3'b101, 5'd1, op_lui),
                ex_def, mem_none, '{regf_m_u_imm, 1'b1}, 1'b0);
    decode_case("auipc", encode_inst(7'h00, 5'd3, 5'd2, 3'b000, 5'd1, op_auipc),
                '{alu_m1_pc, alu_m2_imm, alu_add, cmp_m_rs2, cmp_beq}, mem_none,
                '{regf_m_alu_out, 1'b1}, 1'b0);
    decode_case("jal", encode_inst(7'h40, 5'd3, 5'd2, 3'b010, 5'd1, op_jal),
                ex_def, mem_none, '{regf_m_pc_plus4, 1'b1}, 1'b0);
    decode_case("jalr", encode_inst(7'h00, 5'd3, 5'd2, 3'b000, 5'd1, op_jalr),
                ex_def, mem_none, '{regf_m_pc_plus4, 1'b1}, 1'b0);
    decode_case("bne", encode_inst(7'h00, 5'd3, 5'd2, 3'b001, 5'd1, op_br),
                '{alu_m1_rs1, alu_m2_rs2, alu_add, cmp_m_rs2, cmp_bne}, mem_none,
                '{regf_m_alu_out, 1'b0}, 1'b0);
    decode_case("lw", encode_inst(7'h00, 5'd3, 5'd2, 3'b010, 5'd1, op_load),
                ex_addr, '{1'b1, 1'b0, 3'b010, 3'b000}, '{regf_m_mem_data, 1'b1}, 1'b0);
    decode_case("sh", encode_inst(7'h00, 5'd3, 5'd2, 3'b001, 5'd1, op_store),
                ex_addr, '{1'b0, 1'b1, 3'b000, 3'b001}, '{regf_m_alu_out, 1'b0}, 1'b0);
    decode_case("addi", encode_inst(7'h7f, 5'd3, 5'd2, 3'b000, 5'd1, op_imm),
                '{alu_m1_rs1, alu_m2_imm, alu_add, cmp_m_i_imm, cmp_beq}, mem_none,
                '{regf_m_alu_out, 1'b1}, 1'b0);
    decode_case("sltiu", encode_inst(7'h00, 5'd3, 5'd2, 3'b011, 5'd1, op_imm),
                '{alu_m1_rs1, alu_m2_imm, alu_add, cmp_m_i_imm, cmp_bltu}, mem_none,
                '{regf_m_br_en, 1'b1}, 1'b0);
    decode_case("sub", encode_inst(7'h20, 5'd3, 5'd2, 3'b000, 5'd1, op_reg),
                '{alu_m1_rs1, alu_m2_rs2, alu_sub, cmp_m_rs2, cmp_beq}, mem_none,
                '{regf_m_alu_out, 1'b1}, 1'b0);
    decode_case("sra", encode_inst(7'h20, 5'd3, 5'd2, 3'b101, 5'd1, op_reg),
                '{alu_m1_rs1, alu_m2_rs2, alu_sra, cmp_m_rs2, cmp_beq}, mem_none,
                '{regf_m_alu_out, 1'b1}, 1'b0);
    decode_case("slt", encode_inst(7'h00, 5'd3, 5'd2, 3'b010, 5'd1, op_reg),
                '{alu_m1_rs1, alu_m2_rs2, alu_add, cmp_m_rs2, cmp_blt}, mem_none,
                '{regf_m_br_en, 1'b1}, 1'b0);
    decode_case("ecall", 32'h0000_0073, ex_def, mem_none, '{regf_m_alu_out, 1'b0}, 1'b1);
    decode_case("mul", encode_inst(7'h01, 5'd3, 5'd2, 3'b000, 5'd1, op_reg),
                ex_def, mem_none, '{regf_m_alu_out, 1'b0}, 1'b1);
    issue_fetch(1'b0, encode_inst(7'h00, 5'd3, 5'd2, 3'b010, 5'd1, op_load));
    check_idle_enables("idle after mul");
    decode_case("lw again", encode_inst(7'h00, 5'd3, 5'd2, 3'b010, 5'd1, op_load),
                ex_addr, '{1'b1, 1'b0, 3'b010, 3'b000}, '{regf_m_mem_data, 1'b1}, 1'b0);
    issue_fetch(1'b0, encode_inst(7'h00, 5'd3, 5'd2, 3'b010, 5'd1, op_store));
    check_idle_enables("idle after lw");
    end_test();
endtask

task automatic test_random_fields();
    word_t inst;
    int    gap;
    begin_test("fields_order");
    for (int n = 0; n < N_RANDOM; n++) begin
        gap = $urandom_range(3, 0);
        repeat (gap) begin
            issue_fetch(1'b0, $urandom());
            check_flag("idle valid", 1'b0, id_ex.valid);
            check_order("idle order", last_order, id_ex.order);
        end
        inst = $urandom();
        issue_fetch(1'b1, inst);
        check_word("inst", inst, id_ex.inst);
        check_word("pc", last_pc, id_ex.pc);
        check_order("order", last_order, id_ex.order);
        check_word("i_imm", sign_extend(inst[31:20], 12), id_ex.i_imm);
        check_word("s_imm", sign_extend({inst[31:25], inst[11:7]}, 12), id_ex.s_imm);
        check_word("b_imm", sign_extend({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0},
                                        13), id_ex.b_imm);
        check_word("u_imm", inst & 32'hffff_f000, id_ex.u_imm);
        check_word("j_imm", sign_extend({inst[31], inst[19:12], inst[20], inst[30:21],
                                         1'b0}, 21), id_ex.j_imm);
        check_word("selects", {17'h0, inst[24:20], inst[19:15], inst[11:7]},
                   {17'h0, id_ex.rs2_s, id_ex.rs1_s, id_ex.rd_s});
    end
    end_test();
endtask

`endif

/* tests/tb_decode_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_decode_top;

    import rv32_pkg::*;

    localparam int          CLK_PERIOD   = 8;
    localparam int          RESET_CYCLES = 10;
    localparam int          N_RANDOM     = 20;
    localparam int unsigned SEED         = 32'h00664ff7;
    localparam order_t      ORDER_INIT   = 64'h0000_0000_0000_1000;
    // fetches and writes take two cycles, a random fetch up to eight with its gap
    localparam int TEST_CYCLES = RESET_CYCLES + 2 * 31 + 2 * 16 + 14 + 2 * 17 + 8 * N_RANDOM;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + TEST_CYCLES / 4;

    logic             clk;
    logic             arst_n;
    logic             fetch_valid;
    word_t            fetch_pc;
    word_t            fetch_inst;
    logic             wb_regf_we;
    reg_sel_t         wb_rd_s;
    word_t            wb_rd_v;
    id_ex_stage_reg_t id_ex;

    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int unsigned seed_state;
    string       cur_test;
    word_t       shadow [32];  // expected register contents
    word_t       next_pc;
    word_t       last_pc;      // pc of the latest valid fetch
    order_t      exp_order;
    order_t      last_order;

    decode_top #(
        .ORDER_INIT (ORDER_INIT)
    ) UUT (
        .clk             (clk),
        .arst_n          (arst_n),
        .fetch_valid     (fetch_valid),
        .fetch_pc        (fetch_pc),
        .fetch_inst      (fetch_inst),
        .wb_regf_we      (wb_regf_we),
        .wb_rd_s         (wb_rd_s),
        .wb_rd_v         (wb_rd_v),
        .id_ex_stage_reg (id_ex)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // drives one fetch and returns just before the edge after capture
    task automatic issue_fetch(input logic valid, input word_t inst);
        @(posedge clk);
        #1;
        fetch_valid = valid;
        fetch_inst  = inst;
        fetch_pc    = next_pc;
        if (valid) begin
            last_pc    = next_pc;
            last_order = exp_order;
            exp_order  = exp_order + 64'd1;
            next_pc    = next_pc + 32'd4;
        end
        @(posedge clk);
        #1;
        fetch_valid = 1'b0;
        #6;
    endtask

    task automatic wb_write(input reg_sel_t rd, input word_t value);
        @(posedge clk);
        #1;
        wb_regf_we = 1'b1;
        wb_rd_s    = rd;
        wb_rd_v    = value;
        @(posedge clk);
        #1;
        wb_regf_we = 1'b0;
        #6;
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != test_errors) begin
            tests_failed++;
            $display("test %-14s %0d errors", cur_test, errors - test_errors);
        end else begin
            $display("test %-14s ok", cur_test);
        end
    endtask

    `include "decode_checks.svh"

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, test sequence did not finish",
                 WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        seed_state   = $urandom(SEED);
        arst_n       = 1'b0;
        fetch_valid  = 1'b0;
        fetch_pc     = '0;
        fetch_inst   = '0;
        wb_regf_we   = 1'b0;
        wb_rd_s      = '0;
        wb_rd_v      = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        next_pc      = 32'h0000_0100;
        last_pc      = '0;
        exp_order    = ORDER_INIT;
        last_order   = ORDER_INIT;
        foreach (shadow[i]) shadow[i] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
        #6;
        test_reset_state();
        test_regfile_readback();
        test_x0_and_forwarding();
        test_control_classes();
        test_random_fields();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/decode_top.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_top #(
    parameter rv32_pkg::order_t ORDER_INIT = 64'd0
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       fetch_valid,
    input  rv32_pkg::word_t            fetch_pc,
    input  rv32_pkg::word_t            fetch_inst,
    input  logic                       wb_regf_we,
    input  rv32_pkg::reg_sel_t         wb_rd_s,
    input  rv32_pkg::word_t            wb_rd_v,
    output rv32_pkg::id_ex_stage_reg_t id_ex_stage_reg
);

    import rv32_pkg::*;

    if_id_stage_reg_t if_id_stage_reg;

    inst_predecode #(
        .ORDER_INIT (ORDER_INIT)
    ) u_inst_predecode (
        .clk             (clk),
        .arst_n          (arst_n),
        .fetch_valid     (fetch_valid),
        .fetch_pc        (fetch_pc),
        .fetch_inst      (fetch_inst),
        .if_id_stage_reg (if_id_stage_reg)
    );

    id_stage u_id_stage (
        .clk             (clk),
        .arst_n          (arst_n),
        .if_id_stage_reg (if_id_stage_reg),
        .wb_rd_s         (wb_rd_s),
        .wb_rd_v         (wb_rd_v),
        .wb_regf_we      (wb_regf_we),
        .id_ex_stage_reg (id_ex_stage_reg)
    );

endmodule

`default_nettype wire

/* rtl/inst_predecode.sv */
`timescale 1ns/100ps
`default_nettype none

module inst_predecode #(
    parameter rv32_pkg::order_t ORDER_INIT = 64'd0
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       fetch_valid,
    input  rv32_pkg::word_t            fetch_pc,
    input  rv32_pkg::word_t            fetch_inst,
    output rv32_pkg::if_id_stage_reg_t if_id_stage_reg
);

    import rv32_pkg::*;

    order_t           order_cnt;  // order of the next valid fetch
    if_id_stage_reg_t fetch_dec;

    always_comb begin
        fetch_dec.valid  = 1'b1;
        fetch_dec.inst   = fetch_inst;
        fetch_dec.pc     = fetch_pc;
        fetch_dec.order  = order_cnt;
        fetch_dec.opcode = fetch_inst[6:0];
        fetch_dec.funct3 = fetch_inst[14:12];
        fetch_dec.funct7 = fetch_inst[31:25];
        fetch_dec.rd_s   = fetch_inst[11:7];
        fetch_dec.rs1_s  = fetch_inst[19:15];
        fetch_dec.rs2_s  = fetch_inst[24:20];
        fetch_dec.i_imm  = {{21{fetch_inst[31]}}, fetch_inst[30:20]};
        fetch_dec.s_imm  = {{21{fetch_inst[31]}}, fetch_inst[30:25], fetch_inst[11:7]};
        fetch_dec.b_imm  = {{20{fetch_inst[31]}}, fetch_inst[7], fetch_inst[30:25],
                            fetch_inst[11:8], 1'b0};
        fetch_dec.u_imm  = {fetch_inst[31:12], 12'h000};
        fetch_dec.j_imm  = {{12{fetch_inst[31]}}, fetch_inst[19:12], fetch_inst[20],
                            fetch_inst[30:21], 1'b0};
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_id_stage_reg       <= '0;
            if_id_stage_reg.order <= ORDER_INIT;
            order_cnt             <= ORDER_INIT;
        end else if (fetch_valid) begin
            if_id_stage_reg <= fetch_dec;
            order_cnt       <= order_cnt + 64'd1;
        end else begin
            if_id_stage_reg.valid <= 1'b0;  // bubble, rest held
        end
    end

    order_mono: assert property (@(posedge clk) disable iff (!arst_n)
        if_id_stage_reg.order >= $past(if_id_stage_reg.order));

endmodule

`default_nettype wire

/* decode/id_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module id_stage (
    input  logic                       clk,
    input  logic                       arst_n,
    input  rv32_pkg::if_id_stage_reg_t if_id_stage_reg,
    input  rv32_pkg::reg_sel_t         wb_rd_s,
    input  rv32_pkg::word_t            wb_rd_v,
    input  logic                       wb_regf_we,
    output rv32_pkg::id_ex_stage_reg_t id_ex_stage_reg
);

    import rv32_pkg::*;

    word_t       rs1_v;
    word_t       rs2_v;
    ex_signal_t  ex_signal;
    mem_signal_t mem_signal;
    wb_signal_t  wb_signal;
    logic        illegal;

    regfile u_regfile (
        .clk     (clk),
        .arst_n  (arst_n),
        .regf_we (wb_regf_we),
        .rd_s    (wb_rd_s),
        .rd_v    (wb_rd_v),
        .rs1_s   (if_id_stage_reg.rs1_s),
        .rs2_s   (if_id_stage_reg.rs2_s),
        .rs1_v   (rs1_v),
        .rs2_v   (rs2_v)
    );

    control_decoder u_control_decoder (
        .valid      (if_id_stage_reg.valid),
        .opcode     (if_id_stage_reg.opcode),
        .funct3     (if_id_stage_reg.funct3),
        .funct7     (if_id_stage_reg.funct7),
        .ex_signal  (ex_signal),
        .mem_signal (mem_signal),
        .wb_signal  (wb_signal),
        .illegal    (illegal)
    );

    always_comb begin
        id_ex_stage_reg.valid      = if_id_stage_reg.valid;
        id_ex_stage_reg.illegal    = illegal;
        id_ex_stage_reg.is_stall   = 1'b0;  // no hazard unit yet
        id_ex_stage_reg.inst       = if_id_stage_reg.inst;
        id_ex_stage_reg.pc         = if_id_stage_reg.pc;
        id_ex_stage_reg.order      = if_id_stage_reg.order;
        id_ex_stage_reg.ex_signal  = ex_signal;
        id_ex_stage_reg.mem_signal = mem_signal;
        id_ex_stage_reg.wb_signal  = wb_signal;
        id_ex_stage_reg.i_imm      = if_id_stage_reg.i_imm;
        id_ex_stage_reg.s_imm      = if_id_stage_reg.s_imm;
        id_ex_stage_reg.b_imm      = if_id_stage_reg.b_imm;
        id_ex_stage_reg.u_imm      = if_id_stage_reg.u_imm;
        id_ex_stage_reg.j_imm      = if_id_stage_reg.j_imm;
        id_ex_stage_reg.rs1_v      = rs1_v;
        id_ex_stage_reg.rs2_v      = rs2_v;
        id_ex_stage_reg.rs1_s      = if_id_stage_reg.rs1_s;
        id_ex_stage_reg.rs2_s      = if_id_stage_reg.rs2_s;
        id_ex_stage_reg.rd_s       = if_id_stage_reg.rd_s;
    end

endmodule

`default_nettype wire

/* decode/control_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module control_decoder (
    input  logic                  valid,
    input  rv32_pkg::opcode_t     opcode,
    input  logic [2:0]            funct3,
    input  logic [6:0]            funct7,
    output rv32_pkg::ex_signal_t  ex_signal,
    output rv32_pkg::mem_signal_t mem_signal,
    output rv32_pkg::wb_signal_t  wb_signal,
    output logic                  illegal
);

    import rv32_pkg::*;

    logic bad_op;

    always_comb begin
        ex_signal.alu_m1_sel = alu_m1_rs1;
        ex_signal.alu_m2_sel = alu_m2_rs2;
        ex_signal.alu_ops    = alu_add;
        ex_signal.cmp_m_sel  = cmp_m_rs2;
        ex_signal.cmp_ops    = cmp_beq;

        mem_signal.MemRead   = 1'b0;
        mem_signal.MemWrite  = 1'b0;
        mem_signal.load_ops  = 3'b000;
        mem_signal.store_ops = 3'b000;

        wb_signal.regf_m_sel = regf_m_alu_out;
        wb_signal.regf_we    = 1'b0;

        bad_op = 1'b0;

        case (opcode)
            op_lui: begin
                wb_signal.regf_m_sel = regf_m_u_imm;
                wb_signal.regf_we    = 1'b1;
            end
            op_auipc: begin
                ex_signal.alu_m1_sel = alu_m1_pc;
                ex_signal.alu_m2_sel = alu_m2_imm;
                wb_signal.regf_we    = 1'b1;
            end
            op_jal, op_jalr: begin
                wb_signal.regf_m_sel = regf_m_pc_plus4;  // link value
                wb_signal.regf_we    = 1'b1;
            end
            op_br: begin
                ex_signal.cmp_ops = cmp_ops_t'(funct3);
            end
            op_load: begin
                mem_signal.MemRead   = 1'b1;
                mem_signal.load_ops  = funct3;
                ex_signal.alu_m2_sel = alu_m2_imm;  // address
                wb_signal.regf_m_sel = regf_m_mem_data;
                wb_signal.regf_we    = 1'b1;
            end
            op_store: begin
                mem_signal.MemWrite  = 1'b1;
                mem_signal.store_ops = funct3;
                ex_signal.alu_m2_sel = alu_m2_imm;
            end
            op_imm, op_reg: begin
                wb_signal.regf_we = 1'b1;
                if (opcode == op_imm) begin
                    ex_signal.alu_m2_sel = alu_m2_imm;
                    ex_signal.cmp_m_sel  = cmp_m_i_imm;
                end else if (funct7 != 7'h00 && funct7 != 7'h20) begin
                    bad_op = 1'b1;
                end
                case (funct3)
                    3'b010: begin
                        ex_signal.cmp_ops    = cmp_blt;  // slt
                        wb_signal.regf_m_sel = regf_m_br_en;
                    end
                    3'b011: begin
                        ex_signal.cmp_ops    = cmp_bltu;  // sltu
                        wb_signal.regf_m_sel = regf_m_br_en;
                    end
                    3'b000: begin
                        if (opcode == op_reg && funct7[5]) begin
                            ex_signal.alu_ops = alu_sub;
                        end else begin
                            ex_signal.alu_ops = alu_add;  // no subi
                        end
                    end
                    3'b101: begin
                        ex_signal.alu_ops = funct7[5] ? alu_sra : alu_srl;
                    end
                    default: begin
                        ex_signal.alu_ops = alu_ops_t'(funct3);
                    end
                endcase
            end
            default: begin
                bad_op = 1'b1;  // system, fence and unknown
            end
        endcase

        if (!valid || bad_op) begin
            wb_signal.regf_we   = 1'b0;
            mem_signal.MemRead  = 1'b0;
            mem_signal.MemWrite = 1'b0;
        end

        illegal = valid && bad_op;
    end

    mem_excl: assert final (!(mem_signal.MemRead && mem_signal.MemWrite));

endmodule

`default_nettype wire

/* regfile/regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module regfile (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               regf_we,
    input  rv32_pkg::reg_sel_t rd_s,
    input  rv32_pkg::word_t    rd_v,
    input  rv32_pkg::reg_sel_t rs1_s,
    input  rv32_pkg::reg_sel_t rs2_s,
    output rv32_pkg::word_t    rs1_v,
    output rv32_pkg::word_t    rs2_v
);

    import rv32_pkg::*;

    word_t regs [1:31];  // x0 is not stored

    function automatic word_t read_port(reg_sel_t sel);
        word_t val;
        if (sel == 5'd0) begin
            val = '0;
        end else if (regf_we && rd_s == sel) begin
            val = rd_v;  // same-cycle write-back
        end else begin
            val = regs[sel];
        end
        return val;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regf_we && rd_s != 5'd0) begin
            regs[rd_s] <= rd_v;
        end
    end

    always_comb begin
        rs1_v = read_port(rs1_s);
        rs2_v = read_port(rs2_s);
    end

    we_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(regf_we));

endmodule

`default_nettype wire

/* common/rv32_pkg.sv */
`default_nettype none

package rv32_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_sel_t;
    typedef logic [63:0] order_t;
    typedef logic [6:0]  opcode_t;

    localparam opcode_t op_lui   = 7'b0110111;
    localparam opcode_t op_auipc = 7'b0010111;
    localparam opcode_t op_jal   = 7'b1101111;
    localparam opcode_t op_jalr  = 7'b1100111;
    localparam opcode_t op_br    = 7'b1100011;
    localparam opcode_t op_load  = 7'b0000011;
    localparam opcode_t op_store = 7'b0100011;
    localparam opcode_t op_imm   = 7'b0010011;
    localparam opcode_t op_reg   = 7'b0110011;

    // sra and sub sit in the slt/sltu funct3 slots
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops_t;

    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_ops_t;

    typedef enum logic {alu_m1_rs1, alu_m1_pc} alu_m1_sel_t;
    typedef enum logic {alu_m2_rs2, alu_m2_imm} alu_m2_sel_t;
    typedef enum logic {cmp_m_rs2, cmp_m_i_imm} cmp_m_sel_t;

    typedef enum logic [2:0] {
        regf_m_alu_out,
        regf_m_br_en,
        regf_m_u_imm,
        regf_m_pc_plus4,
        regf_m_mem_data
    } regf_m_sel_t;

    typedef struct packed {
        alu_m1_sel_t alu_m1_sel;
        alu_m2_sel_t alu_m2_sel;
        alu_ops_t    alu_ops;
        cmp_m_sel_t  cmp_m_sel;
        cmp_ops_t    cmp_ops;
    } ex_signal_t;

    typedef struct packed {
        logic       MemRead;
        logic       MemWrite;
        logic [2:0] load_ops;  // funct3 of the load
        logic [2:0] store_ops;
    } mem_signal_t;

    typedef struct packed {
        regf_m_sel_t regf_m_sel;
        logic        regf_we;
    } wb_signal_t;

    typedef struct packed {
        logic       valid;
        word_t      inst;
        word_t      pc;
        order_t     order;
        logic [2:0] funct3;
        logic [6:0] funct7;
        opcode_t    opcode;
        word_t      i_imm;
        word_t      s_imm;
        word_t      b_imm;
        word_t      u_imm;
        word_t      j_imm;
        reg_sel_t   rs1_s;
        reg_sel_t   rs2_s;
        reg_sel_t   rd_s;
    } if_id_stage_reg_t;

    typedef struct packed {
        logic        valid;
        logic        illegal;
        logic        is_stall;
        word_t       inst;
        word_t       pc;
        order_t      order;
        ex_signal_t  ex_signal;
        mem_signal_t mem_signal;
        wb_signal_t  wb_signal;
        word_t       i_imm;
        word_t       s_imm;
        word_t       b_imm;
        word_t       u_imm;
        word_t       j_imm;
        word_t       rs1_v;
        word_t       rs2_v;
        reg_sel_t    rs1_s;
        reg_sel_t    rs2_s;
        reg_sel_t    rd_s;
    } id_ex_stage_reg_t;

endpackage

`default_nettype wire
